/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f rv_id.f --top-module rv_id_tb -o rv_id_sim
out=$(./obj_dir/rv_id_sim)
echo "$out"
if echo "$out" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

/* rv_id.f */
source/rv_id_pkg.sv
source/rv_decoder.sv
source/rv_imm_ext.sv
source/rv_regfile.sv
source/div_fsm.sv
source/div_step_counter.sv
source/div_datapath.sv
source/rv_id_top.sv
verif/rv_id_tb.sv

/* source/div_datapath.sv */
`timescale 1ns/1ps

module div_datapath import rv_id_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            start_i,
    input  logic            step_en_i,
    input  logic            fix_i,
    input  div_req_t        req_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    output logic [XLEN-1:0] result_o,
    output logic [4:0]      rd_o
);

    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    div_req_t        req_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] dvs_q;
    logic [XLEN-1:0] dvd_q;
    logic            neg_q_q;
    logic            neg_r_q;
    logic            zero_q;
    logic            ovf_q;
    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic [XLEN:0]   rem_shift;
    logic [XLEN:0]   rem_diff;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;

    assign is_signed = (req_i.div_op == DIV_DIV) || (req_i.div_op == DIV_REM);
    assign a_neg     = is_signed && dividend_i[XLEN-1];
    assign b_neg     = is_signed && divisor_i[XLEN-1];

    // sign and special-case flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            neg_q_q <= 1'b0;
            neg_r_q <= 1'b0;
            zero_q  <= 1'b0;
            ovf_q   <= 1'b0;
        end else if (start_i) begin
            neg_q_q <= a_neg ^ b_neg;
            // remainder takes the dividend sign
            neg_r_q <= a_neg;
            zero_q  <= (divisor_i == '0);
            ovf_q   <= is_signed && (dividend_i == MIN_NEG) && (divisor_i == '1);
        end
    end

    // trial subtract on the shifted remainder
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign rem_diff  = rem_shift - {1'b0, dvs_q};

    always_ff @(posedge clk) begin
        if (start_i) begin
            req_q <= req_i;
            dvd_q <= dividend_i;
            rem_q <= '0;
            quo_q <= a_neg ? -dividend_i : dividend_i;
            dvs_q <= b_neg ? -divisor_i : divisor_i;
        end else if (step_en_i) begin
            if (!rem_diff[XLEN]) begin
                rem_q <= rem_diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                // restore, keep the shifted value
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    always_comb begin
        quo_fix = neg_q_q ? -quo_q : quo_q;
        rem_fix = neg_r_q ? -rem_q : rem_q;
        // /0: q all ones, r is the dividend
        if (zero_q) begin
            quo_fix = '1;
            rem_fix = dvd_q;
        end else if (ovf_q) begin
            quo_fix = dvd_q;
            rem_fix = '0;
        end
    end

    // only meaningful in the fix cycle
    assign result_o = !fix_i ? '0 :
                      (req_q.div_op == DIV_REM || req_q.div_op == DIV_REMU) ? rem_fix : quo_fix;
    assign rd_o     = req_q.rd_idx;

endmodule

/* source/div_fsm.sv */
`timescale 1ns/1ps

module div_fsm import rv_id_pkg::*; (
    input  logic clk,
    input  logic rst_n_i,
    input  logic start_i,
    input  logic last_i,
    output logic step_en_o,
    output logic cnt_clr_o,
    output logic fix_o,
    output logic done_o,
    output logic busy_o
);

    div_state_e state_q;
    div_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            DIV_IDLE: if (start_i) state_d = DIV_RUN;
            // leave after the last shift-subtract
            DIV_RUN:  if (last_i) state_d = DIV_FIX;
            // single correction cycle
            DIV_FIX:  state_d = DIV_IDLE;
            default:  state_d = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= DIV_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // counter restarts with every accepted divide
    assign cnt_clr_o = (state_q == DIV_IDLE) && start_i;
    assign step_en_o = (state_q == DIV_RUN);
    assign fix_o     = (state_q == DIV_FIX);
    assign done_o    = (state_q == DIV_FIX);
    assign busy_o    = (state_q != DIV_IDLE);

endmodule

/* source/div_step_counter.sv */
`timescale 1ns/1ps

module div_step_counter #(
    parameter int XLEN = 32
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic clr_i,
    input  logic en_i,
    output logic last_o
);

    localparam int CW = $clog2(XLEN);

    logic [CW-1:0] cnt_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || clr_i) begin
            cnt_q <= '0;
        end else if (en_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // step xlen-1 is the final shift
    assign last_o = (cnt_q == CW'(XLEN - 1));

endmodule

/* source/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder import rv_id_pkg::*; (
    input  logic [31:0] instr_i,
    output id_ctrl_t    ctrl_o
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // shared funct3 table for OP and OP-IMM
    function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        // unknown encodings fall out as all zero
        ctrl_o = '0;
        case (instr_i[6:0])
            OPC_OP: begin
                if (funct7 == 7'b0000001) begin
                    // M extension, only the divide half
                    if (funct3[2]) begin
                        ctrl_o.div_en  = 1'b1;
                        ctrl_o.div_op  = div_op_e'(funct3[1:0]);
                        ctrl_o.rs1_idx = instr_i[19:15];
                        ctrl_o.rs2_idx = instr_i[24:20];
                        // result goes back through the wb port, not here
                        ctrl_o.rd_idx  = instr_i[11:7];
                    end
                end else begin
                    ctrl_o.alu_op  = alu_from_f3(funct3, instr_i[30]);
                    ctrl_o.wb_en   = 1'b1;
                    ctrl_o.rs1_idx = instr_i[19:15];
                    ctrl_o.rs2_idx = instr_i[24:20];
                    ctrl_o.rd_idx  = instr_i[11:7];
                end
            end
            OPC_OP_IMM: begin
                // bit 30 only selects srai
                ctrl_o.alu_op   = alu_from_f3(funct3, (funct3 == 3'b101) && instr_i[30]);
                ctrl_o.src2_sel = 2'd1;
                ctrl_o.imm_fmt  = IMM_I;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.rs1_idx  = instr_i[19:15];
                ctrl_o.rd_idx   = instr_i[11:7];
            end
            OPC_LUI: begin
                ctrl_o.alu_op   = ALU_PASS_B;
                ctrl_o.src2_sel = 2'd1;
                ctrl_o.imm_fmt  = IMM_U;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.rd_idx   = instr_i[11:7];
            end
            OPC_AUIPC: begin
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.src1_pc  = 1'b1;
                ctrl_o.src2_sel = 2'd1;
                ctrl_o.imm_fmt  = IMM_U;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.rd_idx   = instr_i[11:7];
            end
            OPC_JAL: begin
                // link value is pc + 4
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.src1_pc  = 1'b1;
                ctrl_o.src2_sel = 2'd2;
                ctrl_o.imm_fmt  = IMM_J;
                ctrl_o.is_jal   = 1'b1;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.rd_idx   = instr_i[11:7];
            end
            OPC_JALR: begin
                ctrl_o.alu_op   = ALU_ADD;
                ctrl_o.src1_pc  = 1'b1;
                ctrl_o.src2_sel = 2'd2;
                ctrl_o.imm_fmt  = IMM_I;
                ctrl_o.is_jalr  = 1'b1;
                ctrl_o.wb_en    = 1'b1;
                ctrl_o.rs1_idx  = instr_i[19:15];
                ctrl_o.rd_idx   = instr_i[11:7];
            end
            OPC_BRANCH: begin
                // 010 and 011 are reserved
                if (funct3[2:1] != 2'b01) begin
                    case (funct3[2:1])
                        2'b00:   ctrl_o.alu_op = ALU_SUB;
                        2'b10:   ctrl_o.alu_op = ALU_SLT;
                        default: ctrl_o.alu_op = ALU_SLTU;
                    endcase
                    ctrl_o.imm_fmt = IMM_B;
                    ctrl_o.is_brc  = 1'b1;
                    ctrl_o.rs1_idx = instr_i[19:15];
                    ctrl_o.rs2_idx = instr_i[24:20];
                end
            end
            OPC_SYSTEM: begin
                // ebreak only, other system ops stay zero
                ctrl_o.trap = (instr_i == 32'h0010_0073);
            end
            default: ;
        endcase
    end

endmodule

/* source/rv_id_pkg.sv */
package rv_id_pkg;

    // major opcodes handled by this decode stage
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // alu control, same width as the old aluctr bus
    typedef enum logic [4:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // low two bits of funct3 (4..7)
    typedef enum logic [1:0] {
        DIV_DIV  = 2'd0,
        DIV_DIVU = 2'd1,
        DIV_REM  = 2'd2,
        DIV_REMU = 2'd3
    } div_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_RUN  = 2'd1,
        DIV_FIX  = 2'd2
    } div_state_e;

    typedef struct packed {
        alu_op_e    alu_op;
        // src1 from pc instead of rs1
        logic       src1_pc;
        // src2: 0 rs2, 1 imm, 2 const 4
        logic [1:0] src2_sel;
        imm_fmt_e   imm_fmt;
        logic       is_jal;
        logic       is_jalr;
        logic       is_brc;
        logic       wb_en;
        logic [4:0] rs1_idx;
        logic [4:0] rs2_idx;
        logic [4:0] rd_idx;
        logic       div_en;
        div_op_e    div_op;
        logic       trap;
    } id_ctrl_t;

    typedef struct packed {
        div_op_e    div_op;
        logic [4:0] rd_idx;
    } div_req_t;

endpackage

/* source/rv_id_top.sv */
`timescale 1ns/1ps

module rv_id_top import rv_id_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            instr_valid_i,
    input  logic [31:0]     instr_i,
    input  logic            wb_en_i,
    input  logic [4:0]      wb_rd_i,
    input  logic [XLEN-1:0] wb_data_i,
    output id_ctrl_t        ctrl_o,
    output logic [XLEN-1:0] rs1_o,
    output logic [XLEN-1:0] rs2_o,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] a0_o,
    output logic            stall_o,
    output logic            div_busy_o,
    output logic            div_done_o,
    output logic [XLEN-1:0] div_result_o,
    output logic [4:0]      div_rd_o
);

    id_ctrl_t ctrl;
    div_req_t div_req;
    logic     div_start;
    logic     step_en;
    logic     cnt_clr;
    logic     last_step;
    logic     fix;

    assign ctrl_o = ctrl;

    // accept a divide only when the unit is free
    assign div_start = instr_valid_i && ctrl.div_en && !div_busy_o;
    // held divide waits here, other ops pass
    assign stall_o   = instr_valid_i && ctrl.div_en && div_busy_o;

    assign div_req.div_op = ctrl.div_op;
    assign div_req.rd_idx = ctrl.rd_idx;

    rv_decoder rv_decoder_u (
        .instr_i (instr_i),
        .ctrl_o  (ctrl)
    );

    rv_imm_ext #(.XLEN(XLEN)) rv_imm_ext_u (
        .instr_imm_i (instr_i[31:7]),
        .imm_fmt_i   (ctrl.imm_fmt),
        .imm_o       (imm_o)
    );

    // single write port, divide results come back through wb
    rv_regfile #(.XLEN(XLEN)) rv_regfile_u (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (ctrl.rs1_idx),
        .rs2_addr_i (ctrl.rs2_idx),
        .rs1_data_o (rs1_o),
        .rs2_data_o (rs2_o),
        .wr_addr_i  (wb_rd_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_en_i),
        .a0_o       (a0_o)
    );

    div_fsm div_fsm_u (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .start_i   (div_start),
        .last_i    (last_step),
        .step_en_o (step_en),
        .cnt_clr_o (cnt_clr),
        .fix_o     (fix),
        .done_o    (div_done_o),
        .busy_o    (div_busy_o)
    );

    div_step_counter #(.XLEN(XLEN)) div_step_counter_u (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .clr_i   (cnt_clr),
        .en_i    (step_en),
        .last_o  (last_step)
    );

    div_datapath #(.XLEN(XLEN)) div_datapath_u (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .start_i    (div_start),
        .step_en_i  (step_en),
        .fix_i      (fix),
        .req_i      (div_req),
        .dividend_i (rs1_o),
        .divisor_i  (rs2_o),
        .result_o   (div_result_o),
        .rd_o       (div_rd_o)
    );

endmodule

/* source/rv_imm_ext.sv */
`timescale 1ns/1ps

module rv_imm_ext import rv_id_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic [24:0]     instr_imm_i,
    input  imm_fmt_e        imm_fmt_i,
    output logic [XLEN-1:0] imm_o
);

    // instr bit k sits at instr_imm_i[k-7]
    logic [31:0] imm_raw;

    always_comb begin
        case (imm_fmt_i)
            IMM_I: imm_raw = {{20{instr_imm_i[24]}}, instr_imm_i[24:13]};
            IMM_S: imm_raw = {{20{instr_imm_i[24]}}, instr_imm_i[24:18], instr_imm_i[4:0]};
            IMM_B: imm_raw = {{20{instr_imm_i[24]}}, instr_imm_i[0], instr_imm_i[23:18],
                              instr_imm_i[4:1], 1'b0};
            IMM_U: imm_raw = {instr_imm_i[24:5], 12'b0};
            IMM_J: imm_raw = {{12{instr_imm_i[24]}}, instr_imm_i[12:5], instr_imm_i[13],
                              instr_imm_i[23:14], 1'b0};
            default: imm_raw = '0;
        endcase
    end

    // widen to xlen keeping the sign
    assign imm_o = XLEN'($signed(imm_raw));

endmodule

/* source/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    input  logic [4:0]      wr_addr_i,
    input  logic [XLEN-1:0] wr_data_i,
    input  logic            wr_en_i,
    output logic [XLEN-1:0] a0_o
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != 5'd0)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // no bypass, a write shows up next cycle
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // x10 tap for end of test checks
    assign a0_o = regs[10];

endmodule

/* verif/rv_id_tb.sv */
`timescale 1ns/1ps

module rv_id_tb import rv_id_pkg::*; ();

    localparam int XLEN            = 32;
    localparam int NUM_DEC         = 42;
    localparam int NUM_RAND_DIV    = 3;
    // four ops, random plus the two special cases, plus the stalled pair
    localparam int NUM_DIV         = 4 * (NUM_RAND_DIV + 2) + 2;
    localparam int NUM_TESTS       = NUM_DEC + 64 + NUM_DIV;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (XLEN + 4) + 200;
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    // opcodes used for random decode
    localparam logic [6:0] DEC_OPCODES [7] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                               OPC_JAL, OPC_JALR, OPC_BRANCH};
    // base alu op per funct3, bit 30 handled apart
    localparam alu_op_e ALU_BY_F3 [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                                          ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};

    logic            clk;
    logic            rst_n_i;
    logic            instr_valid_i;
    logic [31:0]     instr_i;
    logic            wb_en_i;
    logic [4:0]      wb_rd_i;
    logic [XLEN-1:0] wb_data_i;
    id_ctrl_t        ctrl_o;
    logic [XLEN-1:0] rs1_o;
    logic [XLEN-1:0] rs2_o;
    logic [XLEN-1:0] imm_o;
    logic [XLEN-1:0] a0_o;
    logic            stall_o;
    logic            div_busy_o;
    logic            div_done_o;
    logic [XLEN-1:0] div_result_o;
    logic [4:0]      div_rd_o;

    // reference register file
    logic [XLEN-1:0] model_regs [32];
    int value_errs = 0;
    int other_errs = 0;
    int pulse_errs = 0;
    int stall_errs = 0;
    int done_cnt   = 0;

    rv_id_top #(.XLEN(XLEN)) rv_id_top_inst (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_en_i       (wb_en_i),
        .wb_rd_i       (wb_rd_i),
        .wb_data_i     (wb_data_i),
        .ctrl_o        (ctrl_o),
        .rs1_o         (rs1_o),
        .rs2_o         (rs2_o),
        .imm_o         (imm_o),
        .a0_o          (a0_o),
        .stall_o       (stall_o),
        .div_busy_o    (div_busy_o),
        .div_done_o    (div_done_o),
        .div_result_o  (div_result_o),
        .div_rd_o      (div_rd_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // done pulses seen on the clock
    always @(posedge clk) begin
        if (rst_n_i && div_done_o) begin
            done_cnt <= done_cnt + 1;
        end
    end

    // done never lasts two cycles
    done_pulse_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
                                     div_done_o |=> !div_done_o)
        else begin
            pulse_errs++;
            $display("Mismatch div_done_o: got %h exp %h", 1'b1, 1'b0);
        end

    // a divide that is not stalled starts the divider
    div_accept_chk: assert property (@(posedge clk) disable iff (!rst_n_i)
                                     instr_valid_i && ctrl_o.div_en && !stall_o
                                     |=> div_busy_o)
        else begin
            stall_errs++;
            $display("a divide that was not stalled did not start the divider");
        end

    // inputs move 5 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    function automatic logic [XLEN-1:0] expected_imm(input logic [31:0] w,
                                                     input imm_fmt_e fmt);
        logic [31:0] v;
        case (fmt)
            IMM_I:   v = {{20{w[31]}}, w[31:20]};
            IMM_S:   v = {{20{w[31]}}, w[31:25], w[11:7]};
            IMM_B:   v = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:   v = {w[31:12], 12'b0};
            IMM_J:   v = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: v = '0;
        endcase
        return XLEN'($signed(v));
    endfunction

    function automatic id_ctrl_t expected_ctrl(input logic [31:0] w);
        id_ctrl_t   c;
        logic [2:0] f3;
        f3 = w[14:12];
        c  = '0;
        case (w[6:0])
            OPC_OP: begin
                c.rs1_idx = w[19:15];
                c.rs2_idx = w[24:20];
                c.rd_idx  = w[11:7];
                if (w[31:25] == 7'd1) begin
                    // divides only, multiplies give nothing
                    if (f3[2]) begin
                        c.div_en = 1'b1;
                        c.div_op = div_op_e'(f3[1:0]);
                    end else begin
                        c = '0;
                    end
                end else begin
                    c.wb_en  = 1'b1;
                    c.alu_op = ALU_BY_F3[f3];
                    if (w[30] && f3 == 3'b000) c.alu_op = ALU_SUB;
                    if (w[30] && f3 == 3'b101) c.alu_op = ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                c.alu_op   = ALU_BY_F3[f3];
                if (w[30] && f3 == 3'b101) c.alu_op = ALU_SRA;
                c.src2_sel = 2'd1;
                c.imm_fmt  = IMM_I;
                c.wb_en    = 1'b1;
                c.rs1_idx  = w[19:15];
                c.rd_idx   = w[11:7];
            end
            OPC_LUI, OPC_AUIPC: begin
                c.alu_op   = (w[5]) ? ALU_PASS_B : ALU_ADD;
                c.src1_pc  = !w[5];
                c.src2_sel = 2'd1;
                c.imm_fmt  = IMM_U;
                c.wb_en    = 1'b1;
                c.rd_idx   = w[11:7];
            end
            OPC_JAL, OPC_JALR: begin
                // link is pc + 4
                c.alu_op   = ALU_ADD;
                c.src1_pc  = 1'b1;
                c.src2_sel = 2'd2;
                c.wb_en    = 1'b1;
                c.rd_idx   = w[11:7];
                c.is_jal   = w[3];
                c.is_jalr  = !w[3];
                c.imm_fmt  = w[3] ? IMM_J : IMM_I;
                c.rs1_idx  = w[3] ? 5'd0 : w[19:15];
            end
            OPC_BRANCH: begin
                if (f3[2:1] != 2'b01) begin
                    case (f3[2:1])
                        2'b00:   c.alu_op = ALU_SUB;
                        2'b10:   c.alu_op = ALU_SLT;
                        default: c.alu_op = ALU_SLTU;
                    endcase
                    c.imm_fmt = IMM_B;
                    c.is_brc  = 1'b1;
                    c.rs1_idx = w[19:15];
                    c.rs2_idx = w[24:20];
                end
            end
            OPC_SYSTEM: c.trap = (w == 32'h0010_0073);
            default: ;
        endcase
        return c;
    endfunction

    // M extension result rules
    function automatic logic [XLEN-1:0] expected_div(input div_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        case (op)
            DIV_DIV: begin
                if (b == '0) return '1;
                if (a == MIN_NEG && b == '1) return a;
                return $signed(a) / $signed(b);
            end
            DIV_REM: begin
                if (b == '0) return a;
                if (a == MIN_NEG && b == '1) return '0;
                return $signed(a) % $signed(b);
            end
            DIV_DIVU: return (b == '0) ? '1 : a / b;
            default:  return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic logic [31:0] random_instr(input int kind);
        logic [31:0] w;
        w      = $urandom;
        w[6:0] = DEC_OPCODES[kind];
        // keep OP away from the M encodings
        if (kind == 0 && w[31:25] == 7'd1) w[25] = 1'b0;
        return w;
    endfunction

    task automatic write_reg(input logic [4:0] rd, input logic [XLEN-1:0] data);
        wb_en_i   = 1'b1;
        wb_rd_i   = rd;
        wb_data_i = data;
        next_cycle();
        wb_en_i = 1'b0;
        if (rd != 5'd0) model_regs[rd] = data;
    endtask

    // read through an add that names both registers
    task automatic check_read(input logic [4:0] ra, input logic [4:0] rb);
        instr_i = {7'd0, rb, ra, 3'd0, 5'd0, OPC_OP};
        #10;
        assert (rs1_o == model_regs[ra]) else begin
            value_errs++;
            $display("Mismatch rs1_o x%0d: got %h exp %h", ra, rs1_o, model_regs[ra]);
        end
        assert (rs2_o == model_regs[rb]) else begin
            value_errs++;
            $display("Mismatch rs2_o x%0d: got %h exp %h", rb, rs2_o, model_regs[rb]);
        end
        assert (a0_o == model_regs[10]) else begin
            value_errs++;
            $display("Mismatch a0_o: got %h exp %h", a0_o, model_regs[10]);
        end
        next_cycle();
    endtask

    task automatic check_decode(input logic [31:0] w);
        id_ctrl_t        exp_c;
        logic [XLEN-1:0] exp_i;
        exp_c   = expected_ctrl(w);
        exp_i   = expected_imm(w, exp_c.imm_fmt);
        instr_i = w;
        #10;
        assert (ctrl_o == exp_c) else begin
            value_errs++;
            $display("Mismatch ctrl_o for %h: got %h exp %h", w, ctrl_o, exp_c);
        end
        assert (imm_o == exp_i) else begin
            value_errs++;
            $display("Mismatch imm_o for %h: got %h exp %h", w, imm_o, exp_i);
        end
        next_cycle();
    endtask

    task automatic issue_div(input div_op_e op, input logic [4:0] rs1,
                             input logic [4:0] rs2, input logic [4:0] rd);
        instr_i       = {7'b0000001, rs2, rs1, 1'b1, op, rd, OPC_OP};
        instr_valid_i = 1'b1;
    endtask

    // n counts edges from the start edge on
    task automatic wait_done(output int n);
        n = 1;
        while (!div_done_o && n <= XLEN + 4) begin
            next_cycle();
            n++;
        end
    endtask

    task automatic check_div_result(input int n, input logic [XLEN-1:0] exp_r,
                                    input logic [4:0] rd);
        assert (n == XLEN + 1) else begin
            other_errs++;
            $display("divide done after %0d edges instead of %0d", n, XLEN + 1);
        end
        assert (div_result_o == exp_r) else begin
            value_errs++;
            $display("Mismatch div_result_o: got %h exp %h", div_result_o, exp_r);
        end
        assert (div_rd_o == rd) else begin
            value_errs++;
            $display("Mismatch div_rd_o: got %h exp %h", div_rd_o, rd);
        end
    endtask

    task automatic run_div(input div_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        logic [4:0]      rd;
        logic [XLEN-1:0] exp_r;
        int              n;
        int              cnt0;
        rd    = 5'(1 + $urandom % 31);
        exp_r = expected_div(op, a, b);
        write_reg(5'd5, a);
        write_reg(5'd6, b);
        issue_div(op, 5'd5, 5'd6, rd);
        #10;
        assert (ctrl_o == expected_ctrl(instr_i)) else begin
            value_errs++;
            $display("Mismatch ctrl_o for divide: got %h exp %h", ctrl_o,
                     expected_ctrl(instr_i));
        end
        assert (!stall_o) else begin
            value_errs++;
            $display("Mismatch stall_o: got %h exp %h", stall_o, 1'b0);
        end
        cnt0 = done_cnt;
        next_cycle();
        instr_valid_i = 1'b0;
        assert (div_busy_o) else begin
            other_errs++;
            $display("divider not busy after an accepted divide");
        end
        wait_done(n);
        check_div_result(n, exp_r, rd);
        // writeback from the done outputs
        wb_en_i   = 1'b1;
        wb_rd_i   = div_rd_o;
        wb_data_i = div_result_o;
        next_cycle();
        wb_en_i        = 1'b0;
        model_regs[rd] = exp_r;
        assert (done_cnt == cnt0 + 1 && !div_busy_o) else begin
            other_errs++;
            $display("expected one done pulse and an idle divider, saw %0d", done_cnt - cnt0);
        end
        check_read(rd, rd);
    endtask

    task automatic run_stalled_pair();
        logic [XLEN-1:0] a1;
        logic [XLEN-1:0] b1;
        logic [XLEN-1:0] a2;
        logic [XLEN-1:0] b2;
        int              n;
        int              cnt0;
        a1 = $urandom;
        b1 = $urandom & 32'h0000_ffff;
        a2 = $urandom;
        b2 = $urandom & 32'h0000_00ff;
        write_reg(5'd5, a1);
        write_reg(5'd6, b1);
        write_reg(5'd7, a2);
        write_reg(5'd8, b2);
        issue_div(DIV_DIV, 5'd5, 5'd6, 5'd20);
        cnt0 = done_cnt;
        next_cycle();
        // second divide held while the first runs
        issue_div(DIV_REMU, 5'd7, 5'd8, 5'd21);
        n = 1;
        while (!div_done_o && n <= XLEN + 4) begin
            #10;
            assert (stall_o) else begin
                value_errs++;
                $display("Mismatch stall_o: got %h exp %h", stall_o, 1'b1);
            end
            next_cycle();
            n++;
        end
        check_div_result(n, expected_div(DIV_DIV, a1, b1), 5'd20);
        next_cycle();
        #10;
        assert (!stall_o && done_cnt == cnt0 + 1) else begin
            other_errs++;
            $display("held divide not released, or %0d done pulses", done_cnt - cnt0);
        end
        // held divide is taken on this edge
        next_cycle();
        instr_valid_i = 1'b0;
        wait_done(n);
        check_div_result(n, expected_div(DIV_REMU, a2, b2), 5'd21);
        next_cycle();
    endtask

    initial begin
        div_op_e         op;
        logic [XLEN-1:0] b_rand;
        void'($urandom(72));
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        wb_en_i       = 1'b0;
        wb_rd_i       = '0;
        wb_data_i     = '0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (10) @(posedge clk);
        #5;
        rst_n_i = 1'b1;

        // idle divider and a cleared register file
        assert (!div_busy_o && !div_done_o) else begin
            other_errs++;
            $display("divider not idle after reset");
        end
        for (int r = 0; r < 32; r++) begin
            check_read(5'(r), 5'(31 - r));
        end

        // writebacks, x0 included
        for (int r = 0; r < 32; r++) begin
            write_reg(5'(r), $urandom);
            check_read(5'(r), 5'(31 - r));
        end

        for (int i = 0; i < NUM_DEC; i++) begin
            check_decode(random_instr(i % 7));
        end
        // ebreak, ecall and a load opcode
        check_decode(32'h0010_0073);
        check_decode(32'h0000_0073);
        check_decode({$urandom} & 32'hffff_ff80 | 32'h0000_0003);

        for (int k = 0; k < 4; k++) begin
            op = div_op_e'(k[1:0]);
            for (int j = 0; j < NUM_RAND_DIV; j++) begin
                b_rand = $urandom;
                // small signed divisors give wider quotients
                if (j > 0) b_rand = {{24{b_rand[31]}}, b_rand[7:0]};
                run_div(op, $urandom, b_rand);
            end
            run_div(op, $urandom, '0);
            run_div(op, MIN_NEG, '1);
        end
        run_stalled_pair();

        next_cycle();
        $display("errors: value %0d, other %0d, pulse %0d, stall %0d",
                 value_errs, other_errs, pulse_errs, stall_errs);
        if (value_errs + other_errs + pulse_errs + stall_errs == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("errors: value %0d, other %0d, pulse %0d, stall %0d",
                 value_errs, other_errs, pulse_errs, stall_errs);
        $display("Done: errors found");
        $finish;
    end

endmodule
